//--- src/spi_defs.svh
//----------------------------------------
// spi master shared macros
// register map, slave count and widths
//----------------------------------------
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// chip select lines and their index width
`define SPI_NUM_SLAVES 4
`define SPI_CS_W 2

// axi4-lite address and data widths
`define SPI_AXIL_AW 8
`define SPI_DATA_W 32

// half-period divider field
`define SPI_DIV_W 8

// bit counts up to 32 need six bits
`define SPI_LEN_W 6

// byte addresses of the register map
`define SPI_REG_CTRL 8'h00
`define SPI_REG_DIV 8'h04
`define SPI_REG_TX 8'h08
`define SPI_REG_RX 8'h0C
`define SPI_REG_STATUS 8'h10

// axi response codes
`define SPI_RESP_OKAY 2'b00
`define SPI_RESP_SLVERR 2'b10

`endif

//--- src/spi_pkg.sv
//----------------------------------------
// spi master types
// config, axi4-lite channels, engine status
//----------------------------------------
`include "spi_defs.svh"

package spi_pkg;

  // transfer setup, first field is the msb
  typedef struct packed {
    logic                   cpol;
    logic                   cpha;
    logic [`SPI_CS_W-1:0]   cs_sel;
    // 0 is 8 bits, 1 is 16, 2 and 3 are 32
    logic [1:0]             len_code;
    // half-period in system clocks minus one
    logic [`SPI_DIV_W-1:0]  div;
  } spi_cfg_t;

  // everything the host side drives
  typedef struct packed {
    logic                     awvalid;
    logic [`SPI_AXIL_AW-1:0]  awaddr;
    logic                     wvalid;
    logic [`SPI_DATA_W-1:0]   wdata;
    logic [`SPI_DATA_W/8-1:0] wstrb;
    logic                     bready;
    logic                     arvalid;
    logic [`SPI_AXIL_AW-1:0]  araddr;
    logic                     rready;
  } axil_req_t;

  // everything the register file drives back
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [`SPI_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

  // engine state seen by the register file
  typedef struct packed {
    logic                   busy;
    logic                   done_pulse;
    logic [`SPI_DATA_W-1:0] rx_word;
  } spi_eng_stat_t;

  // transfer length in bits
  function automatic logic [`SPI_LEN_W-1:0] len_bits(input logic [1:0] len_code);
    case (len_code)
      2'd0: len_bits = `SPI_LEN_W'(8);
      2'd1: len_bits = `SPI_LEN_W'(16);
      // reserved code falls back to a full word
      default: len_bits = `SPI_LEN_W'(32);
    endcase
  endfunction

endpackage

//--- src/spi_axil_regs.sv
//----------------------------------------
// spi master register file
// axi4-lite slave for ctrl, div, tx, rx
// and status, starts one transfer per tx
//----------------------------------------
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_axil_regs (
  input  logic                     sclk,
  input  logic                     reset,
  input  spi_pkg::axil_req_t       axil_req,
  output spi_pkg::axil_rsp_t       axil_rsp,
  output spi_pkg::spi_cfg_t        cfg,
  output logic [`SPI_DATA_W-1:0]   tx_word,
  output logic                     start,
  input  spi_pkg::spi_eng_stat_t   stat
);

  spi_pkg::spi_cfg_t      cfg_q;
  logic [`SPI_DATA_W-1:0] tx_q;
  logic [`SPI_DATA_W-1:0] rx_q;
  logic [`SPI_DATA_W-1:0] rx_mask;
  logic [`SPI_DATA_W-1:0] rd_data;
  logic [`SPI_DATA_W-1:0] rdata_q;
  logic [1:0]             bresp_q;
  logic [1:0]             rresp_q;
  logic                   bvalid_q;
  logic                   rvalid_q;
  logic                   start_q;
  logic                   done_q;
  logic                   busy_any;
  logic                   wr_go;
  logic                   rd_go;
  logic                   wr_ctrl;
  logic                   wr_div;
  logic                   wr_tx;
  logic                   wr_err;
  logic                   rd_err;

  //----------------------------------------
  // handshake decode
  //----------------------------------------
  // start_q covers the cycle before busy rises
  assign busy_any = stat.busy || start_q;
  // aw and w taken together, blocked by a pending b
  assign wr_go = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_go = axil_req.arvalid && !rvalid_q;

  assign wr_ctrl = (axil_req.awaddr == `SPI_REG_CTRL);
  assign wr_div  = (axil_req.awaddr == `SPI_REG_DIV);
  assign wr_tx   = (axil_req.awaddr == `SPI_REG_TX);
  // unmapped address or tx while a transfer runs
  assign wr_err  = !(wr_ctrl || wr_div || wr_tx) || (wr_tx && busy_any);

  // keeps only the bits of the configured length
  assign rx_mask = {`SPI_DATA_W{1'b1}} >>
                   (`SPI_LEN_W'(`SPI_DATA_W) - spi_pkg::len_bits(cfg_q.len_code));

  // read mux
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      // ctrl layout is cpol, cpha, len_code, cs_sel from bit 0 up
      `SPI_REG_CTRL: rd_data = {26'd0, cfg_q.cs_sel, cfg_q.len_code, cfg_q.cpha, cfg_q.cpol};
      `SPI_REG_DIV: rd_data = {{(`SPI_DATA_W-`SPI_DIV_W){1'b0}}, cfg_q.div};
      `SPI_REG_TX: rd_data = tx_q;
      `SPI_REG_RX: rd_data = rx_q;
      `SPI_REG_STATUS: rd_data = {30'd0, done_q, stat.busy};
      default: rd_err = 1'b1;
    endcase
  end

  //----------------------------------------
  // control state
  //----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      start_q  <= 1'b0;
      done_q   <= 1'b0;
      cfg_q    <= '0;
    end else begin
      // one cycle pulse per accepted tx write
      start_q <= wr_go && wr_tx && !wr_err;
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
      // only byte 0 carries ctrl and div fields
      if (wr_go && wr_ctrl && axil_req.wstrb[0]) begin
        cfg_q.cpol     <= axil_req.wdata[0];
        cfg_q.cpha     <= axil_req.wdata[1];
        cfg_q.len_code <= axil_req.wdata[3:2];
        cfg_q.cs_sel   <= axil_req.wdata[5:4];
      end
      if (wr_go && wr_div && axil_req.wstrb[0]) begin
        cfg_q.div <= axil_req.wdata[`SPI_DIV_W-1:0];
      end
      // sticky done, a new completion wins over the clearing read
      if (stat.done_pulse) begin
        done_q <= 1'b1;
      end else if (rd_go && axil_req.araddr == `SPI_REG_RX) begin
        done_q <= 1'b0;
      end
    end
  end

  //----------------------------------------
  // payload
  //----------------------------------------
  always_ff @(posedge sclk) begin
    if (wr_go) begin
      bresp_q <= wr_err ? `SPI_RESP_SLVERR : `SPI_RESP_OKAY;
    end
    if (rd_go) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? `SPI_RESP_SLVERR : `SPI_RESP_OKAY;
    end
    if (stat.done_pulse) begin
      rx_q <= stat.rx_word & rx_mask;
    end
    // byte lanes of tx follow wstrb
    if (wr_go && wr_tx && !wr_err) begin
      for (int b = 0; b < `SPI_DATA_W/8; b++) begin
        if (axil_req.wstrb[b]) begin
          tx_q[8*b +: 8] <= axil_req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign axil_rsp = '{awready: wr_go, wready: wr_go, bvalid: bvalid_q, bresp: bresp_q,
                      arready: !rvalid_q, rvalid: rvalid_q, rdata: rdata_q,
                      rresp: rresp_q};
  assign cfg     = cfg_q;
  assign tx_word = tx_q;
  assign start   = start_q;

  // stalled responses keep valid and payload until taken
  b_hold: assert property (@(posedge sclk) disable iff (reset)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));
  r_hold: assert property (@(posedge sclk) disable iff (reset)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp));

endmodule

//--- src/spi_clock_gen.sv
//----------------------------------------
// spi clock generator
// half-period divider with edge strobes
//----------------------------------------
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_clock_gen (
  input  logic              sclk,
  input  logic              reset,
  input  logic              run,
  input  spi_pkg::spi_cfg_t cfg,
  output logic              lead_edge,
  output logic              trail_edge,
  output logic              sclk_level
);

  // system clocks left in the current half-period
  logic [`SPI_DIV_W-1:0] half_cnt;
  // set between a leading and a trailing edge
  logic                  phase;
  // last cycle of a half-period
  logic                  tick;

  //----------------------------------------
  // strobes
  //----------------------------------------
  assign tick = run && (half_cnt == '0);

  // leading edge leaves the idle level
  assign lead_edge = tick && !phase;

  // trailing edge returns to it
  assign trail_edge = tick && phase;

  // idle level is cpol and inverts in the active phase
  assign sclk_level = cfg.cpol ^ (run && phase);

  //----------------------------------------
  // divider
  //----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      half_cnt <= '0;
      phase    <= 1'b0;
    end else if (!run) begin
      // preload so the first edge comes a full half-period after run
      half_cnt <= cfg.div;
      phase    <= 1'b0;
    end else if (tick) begin
      half_cnt <= cfg.div;
      phase    <= ~phase;
    end else begin
      half_cnt <= half_cnt - 1'b1;
    end
  end

endmodule

//--- src/spi_shift_engine.sv
//----------------------------------------
// spi shift engine
// chip select sequencing, mosi shifting,
// miso sampling and bit counting
//----------------------------------------
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_shift_engine (
  input  logic                        sclk,
  input  logic                        reset,
  input  spi_pkg::spi_cfg_t           cfg,
  input  logic [`SPI_DATA_W-1:0]      tx_word,
  input  logic                        start,
  output spi_pkg::spi_eng_stat_t      stat,
  output logic                        run,
  input  logic                        lead_edge,
  input  logic                        trail_edge,
  input  logic                        sclk_level,
  output logic                        sclk_out,
  output logic [`SPI_NUM_SLAVES-1:0]  cs_n,
  output logic                        mosi,
  input  logic                        miso
);

  typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_SHIFT, ST_HOLD} eng_state_t;

  eng_state_t                 state;
  logic [`SPI_DATA_W-1:0]     tx_sh;
  logic [`SPI_DATA_W-1:0]     rx_sh;
  logic [`SPI_LEN_W-1:0]      nbits;
  // completed spi clock cycles
  logic [`SPI_LEN_W-1:0]      cyc_cnt;
  logic [`SPI_NUM_SLAVES-1:0] cs_mask;
  logic                       active;
  logic                       sample_edge;
  logic                       shift_edge;
  logic                       shift_en;
  logic                       last_trail;
  logic                       done_q;

  //----------------------------------------
  // edge selection
  //----------------------------------------
  assign nbits       = spi_pkg::len_bits(cfg.len_code);
  assign active      = (state == ST_SETUP) || (state == ST_SHIFT);
  // cpha 0 samples leading, cpha 1 samples trailing
  assign sample_edge = cfg.cpha ? trail_edge : lead_edge;
  assign shift_edge  = cfg.cpha ? lead_edge : trail_edge;
  // first bit is already on mosi, so cpha 1 skips its first leading edge
  assign shift_en    = active && shift_edge && !(cfg.cpha && cyc_cnt == '0);
  assign last_trail  = trail_edge && (cyc_cnt == nbits - 1'b1);
  // low bit at the selected slave
  assign cs_mask     = ~(`SPI_NUM_SLAVES'(1) << cfg.cs_sel);

  //----------------------------------------
  // fsm and chip select
  //----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state   <= ST_IDLE;
      cs_n    <= '1;
      cyc_cnt <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state   <= ST_SETUP;
            cs_n    <= cs_mask;
            cyc_cnt <= '0;
          end
        end
        // cs low, waiting out the first half-period
        ST_SETUP: if (lead_edge) state <= ST_SHIFT;
        ST_SHIFT: if (last_trail) state <= ST_HOLD;
        // one more half-period before releasing cs
        ST_HOLD: begin
          if (lead_edge) begin
            state  <= ST_IDLE;
            cs_n   <= '1;
            done_q <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
      if (active && trail_edge) begin
        cyc_cnt <= cyc_cnt + 1'b1;
      end
    end
  end

  //----------------------------------------
  // shift registers
  //----------------------------------------
  always_ff @(posedge sclk) begin
    if (state == ST_IDLE && start) begin
      // left-aligned so mosi always comes from the msb
      tx_sh <= tx_word << (`SPI_LEN_W'(`SPI_DATA_W) - nbits);
      rx_sh <= '0;
    end else begin
      if (shift_en) begin
        tx_sh <= {tx_sh[`SPI_DATA_W-2:0], 1'b0};
      end
      // miso enters at the lsb, right-aligned after nbits samples
      if (active && sample_edge) begin
        rx_sh <= {rx_sh[`SPI_DATA_W-2:0], miso};
      end
    end
  end

  assign run      = (state != ST_IDLE);
  assign sclk_out = sclk_level;
  assign mosi     = tx_sh[`SPI_DATA_W-1];
  assign stat     = '{busy: run, done_pulse: done_q, rx_word: rx_sh};

  // protocol checks on the pins
  cs_one_low: assert property (@(posedge sclk) disable iff (reset)
    $onehot0(~cs_n) && ((&cs_n) || stat.busy));
  cs_idle_pol: assert property (@(posedge sclk) disable iff (reset)
    (&cs_n) |-> (sclk_out == cfg.cpol));
  mosi_at_sample: assert property (@(posedge sclk) disable iff (reset)
    (active && sample_edge) |=> $stable(mosi));

endmodule

//--- src/spi_master_top.sv
//----------------------------------------
// spi master top level
// axi4-lite registers driving one spi lane
//----------------------------------------
`timescale 1ns/10ps
`include "spi_defs.svh"

module spi_master_top (
  input  logic                       sclk,
  input  logic                       reset,
  input  spi_pkg::axil_req_t         axil_req,
  output spi_pkg::axil_rsp_t         axil_rsp,
  output logic                       sclk_out,
  output logic [`SPI_NUM_SLAVES-1:0] cs_n,
  output logic                       mosi,
  input  logic                       miso
);

  // register file to engine
  spi_pkg::spi_cfg_t      cfg;
  logic [`SPI_DATA_W-1:0] tx_word;
  logic                   start;
  spi_pkg::spi_eng_stat_t stat;

  // engine to clock generator and back
  logic                   run;
  logic                   lead_edge;
  logic                   trail_edge;
  logic                   sclk_level;

  spi_axil_regs regs_i (
    .sclk     (sclk),
    .reset    (reset),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .cfg      (cfg),
    .tx_word  (tx_word),
    .start    (start),
    .stat     (stat)
  );

  spi_clock_gen clk_gen_i (
    .sclk       (sclk),
    .reset      (reset),
    .run        (run),
    .cfg        (cfg),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge),
    .sclk_level (sclk_level)
  );

  spi_shift_engine engine_i (
    .sclk       (sclk),
    .reset      (reset),
    .cfg        (cfg),
    .tx_word    (tx_word),
    .start      (start),
    .stat       (stat),
    .run        (run),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge),
    .sclk_level (sclk_level),
    .sclk_out   (sclk_out),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso)
  );

endmodule

//--- testbench/tb_spi_master.sv
//----------------------------------------
// spi master testbench
// trace driven transfers over axi4-lite
// against a behavioral spi slave
//----------------------------------------
`timescale 1ns/10ps
`include "spi_defs.svh"

module tb_spi_master;

  // handshake wait limit in cycles and status poll limit per transfer
  localparam int WAIT_LIMIT = 200;
  localparam int POLL_LIMIT = 600;

  // each trace column is read as a 32-bit hex word
  typedef struct packed {
    logic [31:0] cpol;
    logic [31:0] cpha;
    logic [31:0] len_code;
    logic [31:0] cs_sel;
    logic [31:0] div;
    logic [31:0] tx;
    logic [31:0] reply;
    logic [31:0] exp_rx;
    logic [31:0] exp_mosi;
  } trace_t;

  logic                       sclk;
  logic                       reset;
  spi_pkg::axil_req_t         req;
  spi_pkg::axil_rsp_t         rsp;
  logic                       sclk_out;
  logic [`SPI_NUM_SLAVES-1:0] cs_n;
  logic                       mosi;
  logic                       miso;

  int          errors;
  int          checks;
  int          lines;
  logic        aborted;
  logic [31:0] lfsr;

  // current line's mode as seen by the slave model
  logic        cur_cpol;
  logic        cur_cpha;
  logic [1:0]  cur_cs;
  int          cur_bits;
  logic [31:0] cur_reply;
  logic        mon_en;

  // slave model state
  logic [31:0] slave_sh;
  logic [31:0] cap;
  int          got_bits;
  logic        seen_cs;
  logic        cs_prev;
  logic        sclk_prev;

  spi_master_top dut_i (
    .sclk     (sclk),
    .reset    (reset),
    .axil_req (req),
    .axil_rsp (rsp),
    .sclk_out (sclk_out),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso)
  );

  initial begin
    sclk = 1'b0;
    forever #5 sclk = ~sclk;
  end

  //----------------------------------------
  // checks and random stalls
  //----------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    aborted = 1'b1;
    $display("timeout while waiting for %s at %0t", what, $time);
  endtask

  // galois lfsr stepped once per bit taken
  function automatic int next_random(input int nbits);
    int value;
    value = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      value = (value << 1) | int'(lfsr[0]);
    end
    return value;
  endfunction

  //----------------------------------------
  // axi4-lite master tasks
  //----------------------------------------
  // inputs change 1 ns after posedge and outputs are read at negedge
  task automatic axil_write(input logic [`SPI_AXIL_AW-1:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int   n;
    int   stall;
    logic ok;
    resp = 2'b11;
    if (aborted) return;
    @(posedge sclk);
    #1;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (!(rsp.awready && rsp.wready) && n < WAIT_LIMIT);
    ok = rsp.awready && rsp.wready;
    @(posedge sclk);
    #1;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    if (!ok) begin
      report_timeout("awready and wready");
      return;
    end
    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (!rsp.bvalid && n < WAIT_LIMIT);
    if (!rsp.bvalid) begin
      report_timeout("bvalid");
      return;
    end
    resp = rsp.bresp;
    // response must not move while bready stays low
    stall = next_random(2);
    repeat (stall) begin
      @(negedge sclk);
      check_val($sformatf("write %02h bvalid held", addr), 32'd1, 32'(rsp.bvalid));
      check_val($sformatf("write %02h bresp held", addr), 32'(resp), 32'(rsp.bresp));
    end
    @(posedge sclk);
    #1;
    req.bready = 1'b1;
    @(posedge sclk);
    #1;
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [`SPI_AXIL_AW-1:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int   n;
    int   stall;
    logic ok;
    data = '0;
    resp = 2'b11;
    if (aborted) return;
    @(posedge sclk);
    #1;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (!rsp.arready && n < WAIT_LIMIT);
    ok = rsp.arready;
    @(posedge sclk);
    #1;
    req.arvalid = 1'b0;
    if (!ok) begin
      report_timeout("arready");
      return;
    end
    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (!rsp.rvalid && n < WAIT_LIMIT);
    if (!rsp.rvalid) begin
      report_timeout("rvalid");
      return;
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    stall = next_random(2);
    repeat (stall) begin
      @(negedge sclk);
      check_val($sformatf("read %02h rvalid held", addr), 32'd1, 32'(rsp.rvalid));
      check_val($sformatf("read %02h rdata held", addr), data, rsp.rdata);
      check_val($sformatf("read %02h rresp held", addr), 32'(resp), 32'(rsp.rresp));
    end
    @(posedge sclk);
    #1;
    req.rready = 1'b1;
    @(posedge sclk);
    #1;
    req.rready = 1'b0;
  endtask

  //----------------------------------------
  // spi slave model and pin monitor
  //----------------------------------------
  // runs 1 ns after each posedge and sees edges as sclk_out changes
  task automatic slave_step;
    logic                       cs_act;
    logic                       lead;
    logic [`SPI_NUM_SLAVES-1:0] cs_exp;
    cs_act = !cs_n[cur_cs];
    // only the selected slave is low
    for (int i = 0; i < `SPI_NUM_SLAVES; i++) begin
      cs_exp[i] = (i != int'(cur_cs));
    end
    if (cs_act && !cs_prev) begin
      // reply goes out msb first from the top of the word
      slave_sh = cur_reply << (32 - cur_bits);
      cap      = '0;
      got_bits = 0;
      seen_cs  = 1'b1;
    end else if (cs_act && sclk_out != sclk_prev) begin
      lead = (sclk_out != cur_cpol);
      // cpha 0 samples on leading edges and cpha 1 on trailing
      if (lead != cur_cpha) begin
        cap = {cap[30:0], mosi};
        got_bits++;
      end else if (got_bits > 0) begin
        slave_sh = slave_sh << 1;
      end
    end
    miso = slave_sh[31];
    if (mon_en) begin
      if (&cs_n) begin
        check_val("idle sclk level", 32'(cur_cpol), 32'(sclk_out));
      end else begin
        check_val("chip select", 32'(cs_exp), 32'(cs_n));
      end
    end
    sclk_prev = sclk_out;
    cs_prev   = cs_act;
  endtask

  initial begin
    forever begin
      @(posedge sclk);
      #1;
      if (!reset) begin
        slave_step();
      end
    end
  end

  //----------------------------------------
  // one transfer per trace line
  //----------------------------------------
  task automatic run_transfer(input trace_t t);
    logic [31:0] ctrl;
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    string       tag;
    tag       = $sformatf("line %0d", lines);
    mon_en    = 1'b0;
    cur_cpol  = t.cpol[0];
    cur_cpha  = t.cpha[0];
    cur_cs    = t.cs_sel[1:0];
    cur_reply = t.reply;
    cur_bits  = (t.len_code[1:0] == 2'd0) ? 8 : (t.len_code[1:0] == 2'd1) ? 16 : 32;
    // ctrl is cpol, cpha, len_code, cs_sel from bit 0 up
    ctrl = {26'd0, t.cs_sel[1:0], t.len_code[1:0], t.cpha[0], t.cpol[0]};
    axil_write(`SPI_REG_CTRL, ctrl, resp);
    check_val({tag, " ctrl bresp"}, 32'(`SPI_RESP_OKAY), 32'(resp));
    axil_write(`SPI_REG_DIV, t.div, resp);
    check_val({tag, " div bresp"}, 32'(`SPI_RESP_OKAY), 32'(resp));
    axil_read(`SPI_REG_CTRL, data, resp);
    check_val({tag, " ctrl readback"}, ctrl, data);
    axil_read(`SPI_REG_DIV, data, resp);
    check_val({tag, " div readback"}, {24'd0, t.div[7:0]}, data);
    mon_en  = 1'b1;
    seen_cs = 1'b0;
    axil_write(`SPI_REG_TX, t.tx, resp);
    check_val({tag, " tx bresp"}, 32'(`SPI_RESP_OKAY), 32'(resp));
    axil_read(`SPI_REG_STATUS, data, resp);
    check_val({tag, " busy after tx"}, 32'd1, 32'(data[0]));
    // second tx while busy is refused and leaves the transfer alone
    axil_write(`SPI_REG_TX, ~t.tx, resp);
    check_val({tag, " tx while busy"}, 32'(`SPI_RESP_SLVERR), 32'(resp));
    polls = 0;
    data  = '0;
    while (!data[1] && polls < POLL_LIMIT && !aborted) begin
      axil_read(`SPI_REG_STATUS, data, resp);
      polls++;
    end
    if (!data[1]) begin
      if (!aborted) begin
        report_timeout("done in STATUS");
      end
      return;
    end
    check_val({tag, " busy at done"}, 32'd0, 32'(data[0]));
    axil_read(`SPI_REG_RX, data, resp);
    check_val({tag, " rx rresp"}, 32'(`SPI_RESP_OKAY), 32'(resp));
    check_val({tag, " rx word"}, t.exp_rx, data);
    axil_read(`SPI_REG_STATUS, data, resp);
    check_val({tag, " done cleared"}, 32'd0, 32'(data[1]));
    check_val({tag, " cs asserted"}, 32'd1, 32'(seen_cs));
    check_val({tag, " mosi bits"}, cur_bits, got_bits);
    check_val({tag, " mosi word"}, t.exp_mosi, cap);
  endtask

  //----------------------------------------
  // main sequence
  //----------------------------------------
  initial begin
    int          fd;
    int          got;
    string       line;
    logic [31:0] f_cpol;
    logic [31:0] f_cpha;
    logic [31:0] f_len;
    logic [31:0] f_cs;
    logic [31:0] f_div;
    logic [31:0] f_tx;
    logic [31:0] f_reply;
    logic [31:0] f_rx;
    logic [31:0] f_mosi;
    req       = '0;
    miso      = 1'b0;
    reset     = 1'b1;
    errors    = 0;
    checks    = 0;
    lines     = 0;
    aborted   = 1'b0;
    lfsr      = 32'hdb553beb;
    cur_cpol  = 1'b0;
    cur_cpha  = 1'b0;
    cur_cs    = 2'd0;
    cur_bits  = 8;
    cur_reply = '0;
    mon_en    = 1'b0;
    slave_sh  = '0;
    cap       = '0;
    got_bits  = 0;
    seen_cs   = 1'b0;
    cs_prev   = 1'b0;
    sclk_prev = 1'b0;
    repeat (16) @(posedge sclk);
    #1;
    reset = 1'b0;
    @(negedge sclk);
    check_val("reset cs_n", 32'({`SPI_NUM_SLAVES{1'b1}}), 32'(cs_n));
    check_val("reset sclk_out", 32'd0, 32'(sclk_out));
    check_val("reset bvalid", 32'd0, 32'(rsp.bvalid));
    check_val("reset rvalid", 32'd0, 32'(rsp.rvalid));
    fd = $fopen("testbench/spi_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file testbench/spi_trace.txt");
    end else begin
      while (!$feof(fd) && !aborted) begin
        got = $fgets(line, fd);
        // skip comment and blank lines
        if (got != 0 && line.len() > 1 && line.getc(0) != "#") begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_cpol, f_cpha, f_len,
                        f_cs, f_div, f_tx, f_reply, f_rx, f_mosi);
          if (got == 9) begin
            lines++;
            run_transfer('{cpol: f_cpol, cpha: f_cpha, len_code: f_len, cs_sel: f_cs,
                           div: f_div, tx: f_tx, reply: f_reply, exp_rx: f_rx,
                           exp_mosi: f_mosi});
          end else begin
            errors++;
            $display("malformed trace line after transfer %0d", lines);
          end
        end
      end
      $fclose(fd);
    end
    if (lines == 0) begin
      errors++;
      $display("no transfers were read from the trace file");
    end
    $display("transfers %0d, checks %0d, errors %0d", lines, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- testbench/spi_trace.txt
# hex columns: cpol cpha len_code cs_sel div tx_word slave_reply
# then expected rx word and expected mosi word seen by the slave
0 0 0 0 01 000000A5 0000003C 0000003C 000000A5
0 1 0 1 02 0000005A 000000C3 000000C3 0000005A
1 0 0 2 01 123456F0 ABCDEF81 00000081 000000F0
1 1 0 3 03 00000081 0000007E 0000007E 00000081
0 0 1 1 01 0000BEEF 00001234 00001234 0000BEEF
0 1 1 2 02 FFFF1357 A5A5C0DE 0000C0DE 00001357
1 0 1 3 01 0000F00D 00008001 00008001 0000F00D
1 1 1 0 04 12348421 00007FFE 00007FFE 00008421
0 0 2 3 00 DEADBEEF 0F1E2D3C 0F1E2D3C DEADBEEF
0 1 2 0 01 80000001 C0FFEE00 C0FFEE00 80000001
1 0 2 1 02 13579BDF 2468ACE0 2468ACE0 13579BDF
1 1 3 2 01 A5A55A5A 5A5AA5A5 5A5AA5A5 A5A55A5A
0 0 0 2 05 FFFFFF00 FFFFFFFF 000000FF 00000000
0 1 3 3 02 00FF00FF FF00FF00 FF00FF00 00FF00FF
1 0 0 0 02 00000001 00000080 00000080 00000001

//--- project.f
+incdir+src
src/spi_pkg.sv
src/spi_axil_regs.sv
src/spi_clock_gen.sv
src/spi_shift_engine.sv
src/spi_master_top.sv
testbench/tb_spi_master.sv

//--- Makefile
# Verilator build and run for the SPI master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh testbench/*.sv)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the exit code of the binary
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "Verification passed" $(LOG)

check: run
	@echo "simulation result in $(LOG) is good"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
